//--- common/sched_defines.svh
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// ========================================
// register file sizing
// ========================================
`define SCHED_ARCH_REGS 16
`define SCHED_PHYS_REGS 32
`define SCHED_PREG_W 5
`define SCHED_AREG_W 4

// wakeup ports from writeback
`define SCHED_WB_WIDTH 2

// issue queue depths
`define SCHED_ALU_IQ_DEPTH 4
`define SCHED_MISC_IQ_DEPTH 2

// running sequence number sent to the reorder buffer
`define SCHED_ROB_IDX_W 4

// ========================================
// exception codes
// ========================================
`define ECODE_INT 6'h00
`define ECODE_SYS 6'h0b
`define ECODE_BRK 6'h0c
`define ECODE_INE 6'h0d
`define ECODE_IPE 6'h0e

`endif

//--- common/sched_pkg.sv
`include "sched_defines.svh"

package sched_pkg;

  typedef logic [`SCHED_PREG_W-1:0] preg_t;
  typedef logic [`SCHED_AREG_W-1:0] areg_t;
  typedef logic [`SCHED_ROB_IDX_W-1:0] rob_idx_t;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_BR,
    OP_CSR,
    OP_TLBINV,
    OP_SYSCALL,
    OP_BRK,
    OP_ILLEGAL
  } op_e;

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MISC,
    UNIT_NONE
  } unit_e;

  // incoming instruction
  typedef struct packed {
    logic        valid;
    logic [15:0] pc;
    op_e         op;
    areg_t       arch_src0;
    areg_t       arch_src1;
    areg_t       arch_dest;
    logic [4:0]  imm;
  } sched_req_t;

  typedef struct packed {
    logic       valid;
    logic [5:0] ecode;
  } excp_t;

  // record for the reorder buffer
  typedef struct packed {
    logic        valid;
    rob_idx_t    rob_idx;
    logic [15:0] pc;
    areg_t       arch_dest;
    preg_t       preg;
    preg_t       old_preg;
    logic        old_preg_valid;
    excp_t       excp;
  } rob_alloc_t;

  typedef struct packed {
    logic [15:0] pc;
    op_e         op;
    logic [4:0]  imm;
    preg_t       psrc0;
    logic        src0_ready;
    preg_t       psrc1;
    logic        src1_ready;
    preg_t       pdest;
    logic        dest_valid;
    rob_idx_t    rob_idx;
  } iq_entry_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] pc;
    op_e         op;
    logic [4:0]  imm;
    preg_t       psrc0;
    preg_t       psrc1;
    preg_t       pdest;
    logic        dest_valid;
    rob_idx_t    rob_idx;
  } issue_t;

  // wakeup bus
  typedef struct packed {
    logic  valid;
    preg_t preg;
  } wb_port_t;

  typedef struct packed {
    wb_port_t [`SCHED_WB_WIDTH-1:0] port;
  } wb_t;

  // true when any writeback port names this preg
  function automatic logic wb_hit(input wb_t wb, input preg_t preg);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < `SCHED_WB_WIDTH; i++) begin
      hit = hit | (wb.port[i].valid && (wb.port[i].preg == preg));
    end
    return hit;
  endfunction

endpackage

//--- src/excp_check.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module excp_check import sched_pkg::*; (
  input  sched_req_t req_i,
  input  logic       csr_has_int_i,
  input  logic [1:0] csr_plv_i,
  output excp_t      excp_o,
  output unit_e      unit_o
);

  logic is_illegal;
  logic is_priv;
  logic is_sys;
  logic is_brk;

  // opcode decode and unit class
  always_comb begin
    is_illegal = 1'b0;
    is_priv    = 1'b0;
    is_sys     = 1'b0;
    is_brk     = 1'b0;
    unit_o     = UNIT_NONE;
    case (req_i.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR: begin
        unit_o = UNIT_ALU;
      end
      OP_BR: begin
        unit_o = UNIT_MISC;
      end
      OP_CSR: begin
        unit_o  = UNIT_MISC;
        is_priv = 1'b1;
      end
      OP_TLBINV: begin
        unit_o     = UNIT_MISC;
        is_priv    = 1'b1;
        // invtlb op field only defines 0..6
        is_illegal = (req_i.imm > 5'd6);
      end
      OP_SYSCALL: begin
        is_sys = 1'b1;
      end
      OP_BRK: begin
        is_brk = 1'b1;
      end
      // OP_ILLEGAL and unused encodings
      default: begin
        is_illegal = 1'b1;
      end
    endcase
  end

  // priority INT > INE > IPE > SYS > BRK
  always_comb begin
    excp_o = '0;
    if (csr_has_int_i) begin
      excp_o.valid = 1'b1;
      excp_o.ecode = `ECODE_INT;
    end else if (is_illegal) begin
      excp_o.valid = 1'b1;
      excp_o.ecode = `ECODE_INE;
    end else if (is_priv && (csr_plv_i == 2'b11)) begin
      excp_o.valid = 1'b1;
      excp_o.ecode = `ECODE_IPE;
    end else if (is_sys) begin
      excp_o.valid = 1'b1;
      excp_o.ecode = `ECODE_SYS;
    end else if (is_brk) begin
      excp_o.valid = 1'b1;
      excp_o.ecode = `ECODE_BRK;
    end
  end

endmodule

//--- rename/free_list.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module free_list (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     alloc_i,
  input  logic                     free_valid_i,
  input  logic [`SCHED_PREG_W-1:0] free_preg_i,
  output logic                     empty_o,
  output logic [`SCHED_PREG_W-1:0] preg_o
);

  // at most PHYS - ARCH registers are unmapped at any time
  localparam int FL_DEPTH = `SCHED_PHYS_REGS - `SCHED_ARCH_REGS;
  localparam int PTR_W    = $clog2(FL_DEPTH);
  localparam int CNT_W    = $clog2(FL_DEPTH + 1);

  logic [`SCHED_PREG_W-1:0] fifo_q [FL_DEPTH];
  logic [PTR_W-1:0]         head_q;
  logic [PTR_W-1:0]         tail_q;
  logic [CNT_W-1:0]         count_q;
  logic                     pop;

  assign empty_o = (count_q == '0);
  assign preg_o  = fifo_q[head_q];
  assign pop     = alloc_i && !empty_o;

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fifo_q[i] <= `SCHED_PREG_W'(`SCHED_ARCH_REGS + i);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= CNT_W'(FL_DEPTH);
    end else begin
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      if (free_valid_i) begin
        fifo_q[tail_q] <= free_preg_i;
        tail_q         <= tail_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(free_valid_i) - CNT_W'(pop);
    end
  end

endmodule

//--- rename/alias_table.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module alias_table import sched_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  areg_t src0_i,
  input  areg_t src1_i,
  input  areg_t dest_i,
  input  logic  write_i,
  input  preg_t preg_i,
  input  wb_t   wb_i,
  output preg_t psrc0_o,
  output preg_t psrc1_o,
  output logic  src0_ready_o,
  output logic  src1_ready_o,
  output preg_t old_preg_o
);

  preg_t                       map_q [`SCHED_ARCH_REGS];
  logic [`SCHED_PHYS_REGS-1:0] ready_q;

  // ========================================
  // lookup
  // ========================================
  assign psrc0_o    = map_q[src0_i];
  assign psrc1_o    = map_q[src1_i];
  assign old_preg_o = map_q[dest_i];

  // same-cycle wakeup counts as ready
  assign src0_ready_o = ready_q[psrc0_o] | wb_hit(wb_i, psrc0_o);
  assign src1_ready_o = ready_q[psrc1_o] | wb_hit(wb_i, psrc1_o);

  // ========================================
  // update
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // identity map, everything ready
      for (int i = 0; i < `SCHED_ARCH_REGS; i++) begin
        map_q[i] <= preg_t'(i);
      end
      ready_q <= '1;
    end else begin
      for (int j = 0; j < `SCHED_WB_WIDTH; j++) begin
        if (wb_i.port[j].valid) begin
          ready_q[wb_i.port[j].preg] <= 1'b1;
        end
      end
      // new destination is not ready yet, overrides a wakeup
      if (write_i) begin
        map_q[dest_i]   <= preg_i;
        ready_q[preg_i] <= 1'b0;
      end
    end
  end

endmodule

//--- rename/rename_stage.sv
`timescale 1ns/1ps

module rename_stage import sched_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  sched_req_t req_i,
  output logic       ready_o,
  input  logic       csr_has_int_i,
  input  logic [1:0] csr_plv_i,
  input  logic       free_valid_i,
  input  preg_t      free_preg_i,
  input  wb_t        wb_i,
  output rob_alloc_t rob_alloc_o,
  input  logic       rob_ready_i,
  output logic       alu_wr_valid_o,
  input  logic       alu_wr_ready_i,
  output logic       misc_wr_valid_o,
  input  logic       misc_wr_ready_i,
  output iq_entry_t  iq_entry_o
);

  logic       stage_valid_q;
  sched_req_t stage_req_q;
  preg_t      stage_preg_q;
  rob_idx_t   stage_rob_idx_q;
  rob_idx_t   rob_idx_q;

  logic  fl_empty;
  preg_t fl_preg;
  logic  accept;
  logic  alloc;
  excp_t excp;
  unit_e unit;
  logic  dest_valid;
  logic  to_iq;
  logic  tgt_ready;
  logic  advance;
  logic  stage_free;

  preg_t at_psrc0;
  preg_t at_psrc1;
  logic  at_src0_ready;
  logic  at_src1_ready;
  preg_t at_old_preg;

  // ========================================
  // handshake and advance
  // ========================================
  assign dest_valid = (stage_req_q.arch_dest != '0);
  assign to_iq      = !excp.valid && (unit != UNIT_NONE);
  assign tgt_ready  = (unit == UNIT_ALU) ? alu_wr_ready_i : misc_wr_ready_i;
  assign advance    = stage_valid_q && rob_ready_i && (!to_iq || tgt_ready);
  assign stage_free = !stage_valid_q || advance;

  // free list gates even instructions without a destination
  assign ready_o = stage_free && !fl_empty;
  assign accept  = req_i.valid && ready_o;
  assign alloc   = accept && (req_i.arch_dest != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid_q <= 1'b0;
      rob_idx_q     <= '0;
    end else begin
      if (stage_free) begin
        stage_valid_q <= accept;
      end
      if (accept) begin
        rob_idx_q <= rob_idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      stage_req_q     <= req_i;
      stage_preg_q    <= fl_preg;
      stage_rob_idx_q <= rob_idx_q;
    end
  end

  // ========================================
  // checks, allocation and rename
  // ========================================
  excp_check i_excp_check (
    .req_i         (stage_req_q),
    .csr_has_int_i (csr_has_int_i),
    .csr_plv_i     (csr_plv_i),
    .excp_o        (excp),
    .unit_o        (unit)
  );

  free_list i_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_i      (alloc),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i),
    .empty_o      (fl_empty),
    .preg_o       (fl_preg)
  );

  // map is written only when the record leaves the stage
  alias_table i_alias_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .src0_i       (stage_req_q.arch_src0),
    .src1_i       (stage_req_q.arch_src1),
    .dest_i       (stage_req_q.arch_dest),
    .write_i      (advance && dest_valid),
    .preg_i       (stage_preg_q),
    .wb_i         (wb_i),
    .psrc0_o      (at_psrc0),
    .psrc1_o      (at_psrc1),
    .src0_ready_o (at_src0_ready),
    .src1_ready_o (at_src1_ready),
    .old_preg_o   (at_old_preg)
  );

  // ========================================
  // outputs
  // ========================================
  always_comb begin
    rob_alloc_o.valid          = stage_valid_q;
    rob_alloc_o.rob_idx        = stage_rob_idx_q;
    rob_alloc_o.pc             = stage_req_q.pc;
    rob_alloc_o.arch_dest      = stage_req_q.arch_dest;
    rob_alloc_o.preg           = dest_valid ? stage_preg_q : '0;
    rob_alloc_o.old_preg       = at_old_preg;
    rob_alloc_o.old_preg_valid = dest_valid;
    rob_alloc_o.excp           = excp;

    iq_entry_o.pc         = stage_req_q.pc;
    iq_entry_o.op         = stage_req_q.op;
    iq_entry_o.imm        = stage_req_q.imm;
    iq_entry_o.psrc0      = at_psrc0;
    iq_entry_o.src0_ready = at_src0_ready;
    iq_entry_o.psrc1      = at_psrc1;
    iq_entry_o.src1_ready = at_src1_ready;
    iq_entry_o.pdest      = dest_valid ? stage_preg_q : '0;
    iq_entry_o.dest_valid = dest_valid;
    iq_entry_o.rob_idx    = stage_rob_idx_q;
  end

  // enter a queue only together with the reorder buffer record
  assign alu_wr_valid_o  = stage_valid_q && rob_ready_i && to_iq && (unit == UNIT_ALU);
  assign misc_wr_valid_o = stage_valid_q && rob_ready_i && to_iq && (unit == UNIT_MISC);

endmodule

//--- issue/issue_queue.sv
`timescale 1ns/1ps

module issue_queue import sched_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      wr_valid_i,
  output logic      wr_ready_o,
  input  iq_entry_t entry_i,
  input  wb_t       wb_i,
  output issue_t    issue_o,
  input  logic      issue_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  iq_entry_t        entries_q [DEPTH];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;
  issue_t           issue_q;

  iq_entry_t wr_entry;
  iq_entry_t head_entry;
  logic      wr_fire;
  logic      head_rdy;
  logic      out_free;
  logic      pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // wakeup folded into the incoming entry and the head
  always_comb begin
    wr_entry            = entry_i;
    wr_entry.src0_ready = entry_i.src0_ready | wb_hit(wb_i, entry_i.psrc0);
    wr_entry.src1_ready = entry_i.src1_ready | wb_hit(wb_i, entry_i.psrc1);

    head_entry = entries_q[head_q];
    head_rdy   = (count_q != '0) &&
                 (head_entry.src0_ready || wb_hit(wb_i, head_entry.psrc0)) &&
                 (head_entry.src1_ready || wb_hit(wb_i, head_entry.psrc1));
  end

  assign wr_ready_o = (count_q != CNT_W'(DEPTH));
  assign wr_fire    = wr_valid_i && wr_ready_o;
  assign out_free   = !issue_q.valid || issue_ready_i;
  assign pop        = head_rdy && out_free;
  assign issue_o    = issue_q;

  // ========================================
  // storage with wakeup snoop
  // ========================================
  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (wb_hit(wb_i, entries_q[i].psrc0)) begin
        entries_q[i].src0_ready <= 1'b1;
      end
      if (wb_hit(wb_i, entries_q[i].psrc1)) begin
        entries_q[i].src1_ready <= 1'b1;
      end
    end
    if (wr_fire) begin
      entries_q[tail_q] <= wr_entry;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (wr_fire) begin
        tail_q <= ptr_inc(tail_q);
      end
      if (pop) begin
        head_q <= ptr_inc(head_q);
      end
      count_q <= count_q + CNT_W'(wr_fire) - CNT_W'(pop);
    end
  end

  // ========================================
  // issue output register
  // ========================================
  // holds while the unit is not ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_q <= '0;
    end else if (out_free) begin
      issue_q.valid <= pop;
      if (pop) begin
        issue_q.pc         <= head_entry.pc;
        issue_q.op         <= head_entry.op;
        issue_q.imm        <= head_entry.imm;
        issue_q.psrc0      <= head_entry.psrc0;
        issue_q.psrc1      <= head_entry.psrc1;
        issue_q.pdest      <= head_entry.pdest;
        issue_q.dest_valid <= head_entry.dest_valid;
        issue_q.rob_idx    <= head_entry.rob_idx;
      end
    end
  end

endmodule

//--- src/sched_top.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module sched_top import sched_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  sched_req_t sched_req_i,
  output logic       sched_ready_o,
  input  logic       csr_has_int_i,
  input  logic [1:0] csr_plv_i,
  input  logic       free_valid_i,
  input  preg_t      free_preg_i,
  input  wb_t        wb_i,
  output rob_alloc_t rob_alloc_o,
  input  logic       rob_ready_i,
  output issue_t     alu_issue_o,
  input  logic       alu_ready_i,
  output issue_t     misc_issue_o,
  input  logic       misc_ready_i
);

  iq_entry_t iq_entry;
  logic      alu_wr_valid;
  logic      alu_wr_ready;
  logic      misc_wr_valid;
  logic      misc_wr_ready;

  rename_stage i_rename_stage (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (sched_req_i),
    .ready_o         (sched_ready_o),
    .csr_has_int_i   (csr_has_int_i),
    .csr_plv_i       (csr_plv_i),
    .free_valid_i    (free_valid_i),
    .free_preg_i     (free_preg_i),
    .wb_i            (wb_i),
    .rob_alloc_o     (rob_alloc_o),
    .rob_ready_i     (rob_ready_i),
    .alu_wr_valid_o  (alu_wr_valid),
    .alu_wr_ready_i  (alu_wr_ready),
    .misc_wr_valid_o (misc_wr_valid),
    .misc_wr_ready_i (misc_wr_ready),
    .iq_entry_o      (iq_entry)
  );

  // both queues see the same entry, wr_valid picks one
  issue_queue #(
    .DEPTH (`SCHED_ALU_IQ_DEPTH)
  ) i_alu_iq (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid_i    (alu_wr_valid),
    .wr_ready_o    (alu_wr_ready),
    .entry_i       (iq_entry),
    .wb_i          (wb_i),
    .issue_o       (alu_issue_o),
    .issue_ready_i (alu_ready_i)
  );

  issue_queue #(
    .DEPTH (`SCHED_MISC_IQ_DEPTH)
  ) i_misc_iq (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid_i    (misc_wr_valid),
    .wr_ready_o    (misc_wr_ready),
    .entry_i       (iq_entry),
    .wb_i          (wb_i),
    .issue_o       (misc_issue_o),
    .issue_ready_i (misc_ready_i)
  );

endmodule

//--- verif/sched_model.svh
`ifndef SCHED_MODEL_SVH
`define SCHED_MODEL_SVH

// ========================================
// reference model state
// ========================================
logic [31:0] lfsr_q;
preg_t       map_m [`SCHED_ARCH_REGS];
bit          rdy_m [`SCHED_PHYS_REGS];
preg_t       free_m [$];
sched_req_t  stage_req_m;
bit          stage_vld_m;
preg_t       stage_preg_m;
int          stage_seq_m;
// index 0 is the alu queue, 1 the misc queue
issue_t      iq_m [2][$];
int          iq_seq_m [2][$];
issue_t      last_m [2];
int          last_seq_m [2];
bit          out_free_m [2];
preg_t       wake_preg_m [$];
int          wake_seq_m [$];
// in-order commit, old mappings wait here until freed
int          cmt_seq_m [$];
preg_t       cmt_old_m [$];
bit          cmt_has_m [$];
bit          done_m [1024];

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        fb;
  val = '0;
  for (int i = 0; i < n; i++) begin
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    val    = {val[30:0], fb};
  end
  return val;
endfunction

// priority INT > INE > IPE > SYS > BRK
function automatic excp_t exp_excp(input op_e op, input logic [4:0] imm,
                                   input logic has_int, input logic [1:0] plv);
  excp_t e;
  logic  ine;
  logic  ipe;
  ine     = (op == OP_ILLEGAL) || ((op == OP_TLBINV) && (imm > 5'd6));
  ipe     = ((op == OP_CSR) || (op == OP_TLBINV)) && (plv == 2'b11);
  e.valid = 1'b1;
  e.ecode = '0;
  if (has_int) begin
    e.ecode = `ECODE_INT;
  end else if (ine) begin
    e.ecode = `ECODE_INE;
  end else if (ipe) begin
    e.ecode = `ECODE_IPE;
  end else if (op == OP_SYSCALL) begin
    e.ecode = `ECODE_SYS;
  end else if (op == OP_BRK) begin
    e.ecode = `ECODE_BRK;
  end else begin
    e = '0;
  end
  return e;
endfunction

// 0 alu, 1 misc, 2 no unit
function automatic int exp_unit(input op_e op);
  case (op)
    OP_ADD, OP_SUB, OP_AND, OP_OR: return 0;
    OP_BR, OP_CSR, OP_TLBINV: return 1;
    default: return 2;
  endcase
endfunction

task automatic model_reset();
  for (int i = 0; i < `SCHED_ARCH_REGS; i++) begin
    map_m[i] = preg_t'(i);
  end
  for (int i = 0; i < `SCHED_PHYS_REGS; i++) begin
    rdy_m[i] = 1'b1;
  end
  for (int i = `SCHED_ARCH_REGS; i < `SCHED_PHYS_REGS; i++) begin
    free_m.push_back(preg_t'(i));
  end
  stage_vld_m   = 1'b0;
  out_free_m[0] = 1'b1;
  out_free_m[1] = 1'b1;
endtask

// record leaves the rename stage
task automatic model_transfer(input excp_t e, input int u);
  issue_t it;
  bit     dv;
  dv = (stage_req_m.arch_dest != '0);
  if (!e.valid && (u != 2)) begin
    it            = '0;
    it.valid      = 1'b1;
    it.pc         = stage_req_m.pc;
    it.op         = stage_req_m.op;
    it.imm        = stage_req_m.imm;
    it.psrc0      = map_m[stage_req_m.arch_src0];
    it.psrc1      = map_m[stage_req_m.arch_src1];
    it.pdest      = dv ? stage_preg_m : '0;
    it.dest_valid = dv;
    it.rob_idx    = rob_idx_t'(stage_seq_m);
    iq_m[u].push_back(it);
    iq_seq_m[u].push_back(stage_seq_m);
  end else if (dv) begin
    // never issues, so its writeback is sent directly
    wake_preg_m.push_back(stage_preg_m);
    wake_seq_m.push_back(stage_seq_m);
  end else begin
    done_m[stage_seq_m] = 1'b1;
  end
  cmt_seq_m.push_back(stage_seq_m);
  cmt_old_m.push_back(map_m[stage_req_m.arch_dest]);
  cmt_has_m.push_back(dv);
  if (dv) begin
    map_m[stage_req_m.arch_dest] = stage_preg_m;
    rdy_m[stage_preg_m]          = 1'b0;
  end
  stage_vld_m = 1'b0;
endtask

`endif

//--- verif/tb_sched.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module tb_sched import sched_pkg::*; ();

  localparam int N_REQ       = 400;
  localparam int FREE_HOLD   = 150;
  localparam int STALL_LIMIT = 400;

  logic       clk;
  logic       rst_n;
  sched_req_t sched_req_i;
  logic       sched_ready_o;
  logic       csr_has_int_i;
  logic [1:0] csr_plv_i;
  logic       free_valid_i;
  preg_t      free_preg_i;
  wb_t        wb_i;
  rob_alloc_t rob_alloc_o;
  logic       rob_ready_i;
  issue_t     alu_issue_o;
  logic       alu_ready_i;
  issue_t     misc_issue_o;
  logic       misc_ready_i;

  // values planned for the next rising edge
  sched_req_t req_n;
  logic       rob_rdy_n;
  logic       alu_rdy_n;
  logic       misc_rdy_n;
  logic       int_n;
  logic [1:0] plv_n;
  wb_t        wb_n;
  int         wb_seq_n [`SCHED_WB_WIDTH];
  logic       free_vld_n;
  preg_t      free_preg_n;

  int mismatch_cnt;
  int fail_cnt;
  int acc_cnt;
  int xfer_cnt;
  int event_cnt;
  int last_events;
  int dry_cnt;
  int cyc;
  int stall;
  bit free_en;

  `include "sched_model.svh"

  sched_top i_sched_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .sched_req_i   (sched_req_i),
    .sched_ready_o (sched_ready_o),
    .csr_has_int_i (csr_has_int_i),
    .csr_plv_i     (csr_plv_i),
    .free_valid_i  (free_valid_i),
    .free_preg_i   (free_preg_i),
    .wb_i          (wb_i),
    .rob_alloc_o   (rob_alloc_o),
    .rob_ready_i   (rob_ready_i),
    .alu_issue_o   (alu_issue_o),
    .alu_ready_i   (alu_ready_i),
    .misc_issue_o  (misc_issue_o),
    .misc_ready_i  (misc_ready_i)
  );

  always #5 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    mismatch_cnt++;
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic report_fail(input string what);
    fail_cnt++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic drive_inputs();
    sched_req_i   <= req_n;
    rob_ready_i   <= rob_rdy_n;
    alu_ready_i   <= alu_rdy_n;
    misc_ready_i  <= misc_rdy_n;
    csr_has_int_i <= int_n;
    csr_plv_i     <= plv_n;
    wb_i          <= wb_n;
    free_valid_i  <= free_vld_n;
    free_preg_i   <= free_preg_n;
  endtask

  // ========================================
  // per-cycle stimulus
  // ========================================
  task automatic plan_inputs();
    // a request is held until it is accepted
    if (!(sched_req_i.valid && !sched_ready_o)) begin
      req_n = '0;
      if ((acc_cnt < N_REQ) && (rand_bits(2) != 0)) begin
        req_n.valid     = 1'b1;
        req_n.pc        = 16'(rand_bits(16));
        req_n.op        = op_e'(4'(rand_bits(4) % 10));
        req_n.arch_src0 = areg_t'(rand_bits(4));
        req_n.arch_src1 = areg_t'(rand_bits(4));
        req_n.arch_dest = areg_t'(rand_bits(4));
        req_n.imm       = 5'(rand_bits(5));
      end
    end
    rob_rdy_n  = (rand_bits(2) != 0);
    alu_rdy_n  = (rand_bits(2) != 0);
    misc_rdy_n = (rand_bits(2) != 0);
    int_n      = (rand_bits(4) == 0);
    plv_n      = 2'(rand_bits(2));
    wb_n       = '0;
    for (int j = 0; j < `SCHED_WB_WIDTH; j++) begin
      if ((wake_preg_m.size() > 0) && (rand_bits(1) != 0)) begin
        wb_n.port[j].valid = 1'b1;
        wb_n.port[j].preg  = wake_preg_m.pop_front();
        wb_seq_n[j]        = wake_seq_m.pop_front();
      end
    end
    // retire records without an old mapping and free the next one
    free_vld_n = 1'b0;
    while ((cmt_seq_m.size() > 0) && done_m[cmt_seq_m[0]] && !cmt_has_m[0]) begin
      cmt_seq_m.delete(0);
      cmt_old_m.delete(0);
      cmt_has_m.delete(0);
    end
    if (free_en && (cmt_seq_m.size() > 0) && done_m[cmt_seq_m[0]] && (rand_bits(1) != 0)) begin
      free_vld_n  = 1'b1;
      free_preg_n = cmt_old_m.pop_front();
      cmt_seq_m.delete(0);
      cmt_has_m.delete(0);
    end
  endtask

  // ========================================
  // checks on stable values at the falling edge
  // ========================================
  task automatic observe();
    issue_t     got;
    logic       unit_rdy;
    string      name;
    excp_t      e;
    int         u;
    bit         dv;
    rob_alloc_t exp_rec;
    logic       exp_ready;

    for (int k = 0; k < 2; k++) begin
      got      = (k == 0) ? alu_issue_o : misc_issue_o;
      unit_rdy = (k == 0) ? alu_ready_i : misc_ready_i;
      name     = (k == 0) ? "alu_issue_o" : "misc_issue_o";
      if (got.valid && out_free_m[k]) begin
        if (iq_m[k].size() == 0) begin
          report_fail({name, " is valid with no instruction pending"});
        end else begin
          last_m[k]     = iq_m[k].pop_front();
          last_seq_m[k] = iq_seq_m[k].pop_front();
          if (!rdy_m[last_m[k].psrc0] || !rdy_m[last_m[k].psrc1]) begin
            report_fail({name, " issued before its sources were ready"});
          end
        end
      end
      // also covers holding steady, valid included, under back-pressure
      if ((got.valid || !out_free_m[k]) && (got != last_m[k])) begin
        report_mismatch(name, 64'(got), 64'(last_m[k]));
      end
      if (got.valid && unit_rdy) begin
        event_cnt++;
        if (last_m[k].dest_valid) begin
          wake_preg_m.push_back(last_m[k].pdest);
          wake_seq_m.push_back(last_seq_m[k]);
        end else begin
          done_m[last_seq_m[k]] = 1'b1;
        end
      end
      out_free_m[k] = !got.valid || unit_rdy;
    end

    for (int j = 0; j < `SCHED_WB_WIDTH; j++) begin
      if (wb_i.port[j].valid) begin
        rdy_m[wb_i.port[j].preg] = 1'b1;
        done_m[wb_seq_n[j]]      = 1'b1;
      end
    end

    if (stage_vld_m) begin
      e  = exp_excp(stage_req_m.op, stage_req_m.imm, csr_has_int_i, csr_plv_i);
      u  = exp_unit(stage_req_m.op);
      dv = (stage_req_m.arch_dest != '0);
      exp_rec                = '0;
      exp_rec.valid          = 1'b1;
      exp_rec.rob_idx        = rob_idx_t'(stage_seq_m);
      exp_rec.pc             = stage_req_m.pc;
      exp_rec.arch_dest      = stage_req_m.arch_dest;
      exp_rec.preg           = dv ? stage_preg_m : '0;
      exp_rec.old_preg       = map_m[stage_req_m.arch_dest];
      exp_rec.old_preg_valid = dv;
      exp_rec.excp           = e;
      if (rob_alloc_o != exp_rec) begin
        report_mismatch("rob_alloc_o", 64'(rob_alloc_o), 64'(exp_rec));
      end
      if (rob_ready_i && (e.valid || (u == 2) || (iq_m[u].size() <
          ((u == 0) ? `SCHED_ALU_IQ_DEPTH : `SCHED_MISC_IQ_DEPTH)))) begin
        model_transfer(e, u);
        xfer_cnt++;
        event_cnt++;
      end
    end else if (rob_alloc_o.valid) begin
      report_fail("reorder buffer record shown without an accepted request");
    end

    exp_ready = !stage_vld_m && (free_m.size() > 0);
    if (sched_ready_o !== exp_ready) begin
      report_mismatch("sched_ready_o", 64'(sched_ready_o), 64'(exp_ready));
    end
    if (free_m.size() == 0) begin
      dry_cnt++;
    end
    if (sched_req_i.valid && sched_ready_o) begin
      stage_vld_m  = 1'b1;
      stage_req_m  = sched_req_i;
      stage_seq_m  = acc_cnt;
      stage_preg_m = '0;
      if (sched_req_i.arch_dest != '0) begin
        stage_preg_m = free_m.pop_front();
      end
      acc_cnt++;
      event_cnt++;
    end
    if (free_valid_i) begin
      free_m.push_back(free_preg_i);
    end
  endtask

  function automatic bit drained();
    return (xfer_cnt == N_REQ) && (iq_m[0].size() == 0) && (iq_m[1].size() == 0) &&
           !alu_issue_o.valid && !misc_issue_o.valid;
  endfunction

  initial begin
    lfsr_q        = 32'he3a4e793;
    clk           = 1'b0;
    rst_n         = 1'b0;
    sched_req_i   = '0;
    csr_has_int_i = 1'b0;
    csr_plv_i     = 2'b00;
    free_valid_i  = 1'b0;
    free_preg_i   = '0;
    wb_i          = '0;
    rob_ready_i   = 1'b0;
    alu_ready_i   = 1'b0;
    misc_ready_i  = 1'b0;
    req_n         = '0;
    free_preg_n   = '0;
    mismatch_cnt  = 0;
    fail_cnt      = 0;
    acc_cnt       = 0;
    xfer_cnt      = 0;
    event_cnt     = 0;
    dry_cnt       = 0;
    cyc           = 0;
    stall         = 0;
    free_en       = 1'b0;
    model_reset();

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (rob_alloc_o.valid || alu_issue_o.valid || misc_issue_o.valid || !sched_ready_o) begin
      report_fail("outputs are not idle after reset");
    end

    // frees are held back at first so the free list runs dry
    while (!drained() && (stall < STALL_LIMIT)) begin
      plan_inputs();
      @(posedge clk);
      drive_inputs();
      @(negedge clk);
      last_events = event_cnt;
      observe();
      cyc++;
      if (cyc == FREE_HOLD) begin
        free_en = 1'b1;
      end
      stall = (event_cnt != last_events) ? 0 : stall + 1;
    end
    if (stall >= STALL_LIMIT) begin
      report_fail("timeout while waiting for the scheduler to make progress");
    end
    if (dry_cnt == 0) begin
      report_fail("free list never ran out while frees were held back");
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if ((mismatch_cnt == 0) && (fail_cnt == 0)) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+common
+incdir+verif
common/sched_pkg.sv
src/excp_check.sv
rename/free_list.sv
rename/alias_table.sv
rename/rename_stage.sv
issue/issue_queue.sv
src/sched_top.sv
verif/tb_sched.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps
TOP       = tb_sched
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
